// ==== filelist.f ====
hmr_pkg.sv
hmr_config_regs.sv
hmr_vote_stage.sv
hmr_output_route.sv
hmr_unit.sv
tb_hmr_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the HMR unit testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing \
  --top-module tb_hmr_unit \
  --Mdir "$BUILD_DIR" \
  -o sim_tb_hmr_unit \
  -f filelist.f

"$BUILD_DIR"/sim_tb_hmr_unit | tee "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation finished without failure"

// ==== tb_hmr_unit.sv ====
// Directed testbench for the HMR unit with clock, reset, watchdog, check task and test tasks
`timescale 1ns/10ps

module tb_hmr_unit
  import hmr_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  // Cycle budget per test, the saturation run dominates
  localparam int TEST_CYCLES    = RESET_CYCLES + 60 + 40 + 20 + 400 + 60;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                      clk_i;
  logic                      reset_i;
  cfg_req_t                  cfg_req;
  logic [CFG_DATA_W-1:0]     cfg_rdata;
  core_in_t  [NUM_CORES-1:0] sys_inputs;
  core_out_t [NUM_CORES-1:0] sys_outputs;
  core_in_t  [NUM_CORES-1:0] core_inputs;
  core_out_t [NUM_CORES-1:0] core_outputs;
  logic [TMR_CORES-1:0]      tmr_error;
  logic                      tmr_failure;
  logic [NUM_DMR_GROUPS-1:0] dmr_failure;
  hmr_mode_e                 mode;

  hmr_unit u_dut (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .cfg_req_i      (cfg_req),
    .cfg_rdata_o    (cfg_rdata),
    .sys_inputs_i   (sys_inputs),
    .sys_outputs_o  (sys_outputs),
    .core_inputs_o  (core_inputs),
    .core_outputs_i (core_outputs),
    .tmr_error_o    (tmr_error),
    .tmr_failure_o  (tmr_failure),
    .dmr_failure_o  (dmr_failure),
    .mode_o         (mode)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk_i = ~clk_i;
    end
  end

  // Watchdog
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic core_out_t rand_core_out();
    core_out_t   r;
    logic [31:0] w;
    w       = $urandom();
    r.req   = w[0];
    r.we    = w[1];
    r.addr  = w[31:16];
    r.wdata = $urandom();
    return r;
  endfunction

  function automatic core_in_t rand_core_in();
    core_in_t    r;
    logic [31:0] w;
    w           = $urandom();
    r.fetch_en  = w[0];
    r.boot_addr = w[31:16];
    r.irq_id    = $urandom();
    return r;
  endfunction

  // Same bundle with one bit inverted
  function automatic core_out_t flip_bit(input core_out_t v, input int idx);
    logic [OUT_W-1:0] bits;
    bits      = v;
    bits[idx] = ~bits[idx];
    return core_out_t'(bits);
  endfunction

  task automatic drive_data(input core_in_t [NUM_CORES-1:0] si,
                            input core_out_t [NUM_CORES-1:0] co);
    @(posedge clk_i);
    sys_inputs   <= si;
    core_outputs <= co;
    @(negedge clk_i);
  endtask

  // Core outputs held for a number of rising edges, then replaced
  task automatic hold_outputs(input core_out_t [NUM_CORES-1:0] co, input int cycles,
                              input core_out_t [NUM_CORES-1:0] after);
    @(posedge clk_i);
    core_outputs <= co;
    repeat (cycles) @(posedge clk_i);
    core_outputs <= after;
  endtask

  task automatic cfg_write(input logic [CFG_ADDR_W-1:0] addr,
                           input logic [CFG_DATA_W-1:0] data);
    cfg_req_t r;
    r.we    = 1'b1;
    r.addr  = addr;
    r.wdata = data;
    @(posedge clk_i);
    cfg_req <= r;
    @(posedge clk_i);
    cfg_req.we <= 1'b0;
  endtask

  task automatic check_reg(input logic [CFG_ADDR_W-1:0] addr,
                           input logic [CFG_DATA_W-1:0] expected, input string what);
    cfg_req_t r;
    r.we    = 1'b0;
    r.addr  = addr;
    r.wdata = '0;
    @(posedge clk_i);
    cfg_req <= r;
    @(negedge clk_i);
    check_equal(64'(cfg_rdata), 64'(expected), what);
  endtask

  task automatic check_status_clear(input string what);
    check_equal(64'(tmr_error), 64'(0), {what, " tmr_error"});
    check_equal(64'(tmr_failure), 64'(0), {what, " tmr_failure"});
    check_equal(64'(dmr_failure), 64'(0), {what, " dmr_failure"});
  endtask

  task automatic test_reset_indep();
    core_in_t  [NUM_CORES-1:0] si;
    core_out_t [NUM_CORES-1:0] co;
    check_equal(64'(mode), 64'(MODE_INDEP), "mode after reset");
    check_status_clear("after reset");
    check_reg(ADDR_MODE, 8'(MODE_INDEP), "mode register after reset");
    for (int i = 0; i < NUM_CORES; i++) begin
      check_reg(4'(ADDR_CNT_BASE + i), '0, "counter after reset");
    end
    // Every port passes straight through
    for (int n = 0; n < 8; n++) begin
      for (int i = 0; i < NUM_CORES; i++) begin
        si[i] = rand_core_in();
        co[i] = rand_core_out();
      end
      drive_data(si, co);
      for (int i = 0; i < NUM_CORES; i++) begin
        check_equal(64'(core_inputs[i]), 64'(si[i]), "indep core input");
        check_equal(64'(sys_outputs[i]), 64'(co[i]), "indep system output");
      end
      check_status_clear("indep");
    end
  endtask

  task automatic test_tmr_vote();
    core_in_t  [NUM_CORES-1:0] si;
    core_out_t [NUM_CORES-1:0] co;
    core_out_t                 base;
    int                        idx_a;
    int                        idx_b;
    cfg_write(ADDR_MODE, 8'(MODE_TMR));
    @(negedge clk_i);
    check_equal(64'(mode), 64'(MODE_TMR), "mode after TMR write");
    base = rand_core_out();
    for (int k = 0; k < TMR_CORES; k++) begin
      for (int i = 0; i < NUM_CORES; i++) begin
        si[i] = rand_core_in();
        co[i] = base;
      end
      co[3] = rand_core_out();
      idx_a = $urandom() % OUT_W;
      co[k] = flip_bit(base, idx_a);
      drive_data(si, co);
      for (int i = 0; i < TMR_CORES; i++) begin
        check_equal(64'(core_inputs[i]), 64'(si[0]), "TMR core input fan-out");
      end
      check_equal(64'(core_inputs[3]), 64'(si[3]), "TMR core 3 input");
      check_equal(64'(sys_outputs[0]), 64'(base), "TMR voted port 0");
      check_equal(64'(sys_outputs[1]), 64'(0), "TMR port 1 disabled");
      check_equal(64'(sys_outputs[2]), 64'(0), "TMR port 2 disabled");
      check_equal(64'(sys_outputs[3]), 64'(co[3]), "TMR port 3 passes core 3");
      check_equal(64'(tmr_error), 64'(1 << k), "TMR single error flag");
      check_equal(64'(tmr_failure), 64'(0), "TMR no failure with one error");
      check_equal(64'(dmr_failure), 64'(0), "TMR dmr_failure gated");
    end
    // Two cores wrong in different bits
    idx_a = $urandom() % OUT_W;
    idx_b = (idx_a + 1 + $urandom() % (OUT_W - 1)) % OUT_W;
    co[0] = base;
    co[1] = flip_bit(base, idx_a);
    co[2] = flip_bit(base, idx_b);
    drive_data(si, co);
    check_equal(64'(tmr_error), 64'(3'b110), "TMR two error flags");
    check_equal(64'(tmr_failure), 64'(1), "TMR failure with two errors");
  endtask

  task automatic test_dmr_check();
    core_in_t  [NUM_CORES-1:0] si;
    core_out_t [NUM_CORES-1:0] co;
    core_out_t                 a;
    core_out_t                 b;
    cfg_write(ADDR_MODE, 8'(MODE_DMR));
    @(negedge clk_i);
    check_equal(64'(mode), 64'(MODE_DMR), "mode after DMR write");
    for (int i = 0; i < NUM_CORES; i++) begin
      si[i] = rand_core_in();
    end
    a     = rand_core_out();
    b     = rand_core_out();
    co[0] = a;
    co[1] = a;
    co[2] = b;
    co[3] = b;
    drive_data(si, co);
    check_equal(64'(core_inputs[0]), 64'(si[0]), "DMR pair 0 input core 0");
    check_equal(64'(core_inputs[1]), 64'(si[0]), "DMR pair 0 input core 1");
    check_equal(64'(core_inputs[2]), 64'(si[2]), "DMR pair 1 input core 2");
    check_equal(64'(core_inputs[3]), 64'(si[2]), "DMR pair 1 input core 3");
    check_equal(64'(sys_outputs[0]), 64'(a), "DMR port 0 main core");
    check_equal(64'(sys_outputs[1]), 64'(0), "DMR port 1 disabled");
    check_equal(64'(sys_outputs[2]), 64'(b), "DMR port 2 main core");
    check_equal(64'(sys_outputs[3]), 64'(0), "DMR port 3 disabled");
    check_status_clear("DMR matching pairs");
    co[3] = flip_bit(b, $urandom() % OUT_W);
    drive_data(si, co);
    check_equal(64'(dmr_failure), 64'(2'b10), "DMR pair 1 failure only");
    check_equal(64'(sys_outputs[2]), 64'(b), "DMR port 2 keeps main core");
    check_equal(64'(tmr_error), 64'(0), "DMR tmr_error gated");
    check_equal(64'(tmr_failure), 64'(0), "DMR tmr_failure gated");
  endtask

  task automatic test_mismatch_counters();
    core_in_t  [NUM_CORES-1:0] si;
    core_out_t [NUM_CORES-1:0] good;
    core_out_t [NUM_CORES-1:0] bad;
    core_out_t                 g;
    g = rand_core_out();
    for (int i = 0; i < NUM_CORES; i++) begin
      si[i]   = rand_core_in();
      good[i] = g;
    end
    cfg_write(ADDR_MODE, 8'(MODE_DMR));
    drive_data(si, good);
    for (int i = 0; i < NUM_CORES; i++) begin
      cfg_write(4'(ADDR_CNT_BASE + i), 8'h00);
      check_reg(4'(ADDR_CNT_BASE + i), '0, "counter after clear");
    end
    // Pair 0 differs for five edges, both cores are blamed
    bad    = good;
    bad[1] = flip_bit(g, $urandom() % OUT_W);
    hold_outputs(bad, 5, good);
    check_reg(ADDR_CNT_BASE, 8'd5, "core 0 counter after DMR mismatch");
    check_reg(4'(ADDR_CNT_BASE + 1), 8'd5, "core 1 counter after DMR mismatch");
    check_reg(4'(ADDR_CNT_BASE + 2), 8'd0, "core 2 counter untouched");
    check_reg(4'(ADDR_CNT_BASE + 3), 8'd0, "core 3 counter untouched");
    // Any write data clears
    cfg_write(ADDR_CNT_BASE, 8'hA5);
    check_reg(ADDR_CNT_BASE, 8'd0, "core 0 counter cleared");
    check_reg(4'(ADDR_CNT_BASE + 1), 8'd5, "core 1 counter kept");
    // In TMR only the dissenting core counts
    cfg_write(ADDR_MODE, 8'(MODE_TMR));
    bad    = good;
    bad[2] = flip_bit(g, $urandom() % OUT_W);
    hold_outputs(bad, 3, good);
    check_reg(4'(ADDR_CNT_BASE + 2), 8'd3, "core 2 counter after TMR mismatch");
    check_reg(ADDR_CNT_BASE, 8'd0, "core 0 counter in TMR");
    // Long DMR mismatch on pair 1
    cfg_write(ADDR_MODE, 8'(MODE_DMR));
    bad    = good;
    bad[3] = flip_bit(g, $urandom() % OUT_W);
    hold_outputs(bad, 300, good);
    check_reg(4'(ADDR_CNT_BASE + 2), 8'd255, "core 2 counter saturated");
    check_reg(4'(ADDR_CNT_BASE + 3), 8'd255, "core 3 counter saturated");
  endtask

  task automatic test_mode_writes();
    cfg_write(ADDR_MODE, 8'(MODE_DMR));
    cfg_write(ADDR_MODE, 8'd3);
    @(negedge clk_i);
    check_equal(64'(mode), 64'(MODE_DMR), "mode kept after illegal write");
    check_reg(ADDR_MODE, 8'(MODE_DMR), "mode register after illegal write");
    for (int a = 1; a < 16; a++) begin
      if (a < 4 || a > 7) begin
        check_reg(4'(a), 8'd0, "unmapped address reads zero");
      end
    end
  endtask

  initial begin
    void'($urandom(1));
    reset_i    = 1'b1;
    cfg_req    = '0;
    sys_inputs = '0;
    // Cores disagree throughout reset so only mode gating keeps the status at zero
    for (int i = 0; i < NUM_CORES; i++) begin
      core_outputs[i] = rand_core_out();
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    test_reset_indep();
    test_tmr_vote();
    test_dmr_check();
    test_mismatch_counters();
    test_mode_writes();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== hmr_unit.sv ====
// Top level of the hybrid modular redundancy unit for a four-core cluster
`timescale 1ns/10ps

module hmr_unit
  import hmr_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,

  // Configuration port
  input  cfg_req_t                  cfg_req_i,
  output logic [CFG_DATA_W-1:0]     cfg_rdata_o,

  // System side
  input  core_in_t  [NUM_CORES-1:0] sys_inputs_i,
  output core_out_t [NUM_CORES-1:0] sys_outputs_o,

  // Core side
  output core_in_t  [NUM_CORES-1:0] core_inputs_o,
  input  core_out_t [NUM_CORES-1:0] core_outputs_i,

  // Status
  output logic [TMR_CORES-1:0]      tmr_error_o,
  output logic                      tmr_failure_o,
  output logic [NUM_DMR_GROUPS-1:0] dmr_failure_o,
  output hmr_mode_e                 mode_o
);

  hmr_mode_e            mode;
  core_out_t            tmr_voted;
  logic [NUM_CORES-1:0] incr_mismatch;

  assign mode_o = mode;

  // Decode: registers and counters
  hmr_config_regs u_config_regs (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cfg_req_i       (cfg_req_i),
    .cfg_rdata_o     (cfg_rdata_o),
    .incr_mismatch_i (incr_mismatch),
    .mode_o          (mode)
  );

  // Execute: voting and pair checking
  hmr_vote_stage u_vote_stage (
    .mode_i          (mode),
    .core_outputs_i  (core_outputs_i),
    .tmr_voted_o     (tmr_voted),
    .tmr_error_o     (tmr_error_o),
    .tmr_failure_o   (tmr_failure_o),
    .dmr_failure_o   (dmr_failure_o),
    .incr_mismatch_o (incr_mismatch)
  );

  // Result: fan-out and port routing
  hmr_output_route u_output_route (
    .mode_i          (mode),
    .sys_inputs_i    (sys_inputs_i),
    .core_outputs_i  (core_outputs_i),
    .tmr_voted_i     (tmr_voted),
    .core_inputs_o   (core_inputs_o),
    .sys_outputs_o   (sys_outputs_o)
  );

endmodule

// ==== hmr_output_route.sv ====
// Mode-dependent input fan-out to the cores and output routing to the system ports
`timescale 1ns/10ps

module hmr_output_route
  import hmr_pkg::*;
(
  input  hmr_mode_e                 mode_i,

  // System side inputs and core side outputs
  input  core_in_t  [NUM_CORES-1:0] sys_inputs_i,
  input  core_out_t [NUM_CORES-1:0] core_outputs_i,
  input  core_out_t                 tmr_voted_i,

  // Routed results
  output core_in_t  [NUM_CORES-1:0] core_inputs_o,
  output core_out_t [NUM_CORES-1:0] sys_outputs_o
);

  // Every core of a group sees the inputs of the group's main core
  always_comb begin
    for (int i = 0; i < NUM_CORES; i++) begin
      core_inputs_o[i] = sys_inputs_i[i];
      case (mode_i)
        MODE_TMR: begin
          if (i < TMR_CORES) begin
            core_inputs_o[i] = sys_inputs_i[0];
          end
        end
        MODE_DMR: begin
          // Main core of the pair is the even one
          core_inputs_o[i] = sys_inputs_i[(i / 2) * 2];
        end
        default: begin
        end
      endcase
    end
  end

  // Main core port carries the group result, secondary ports read zero
  always_comb begin
    sys_outputs_o = core_outputs_i;
    case (mode_i)
      MODE_TMR: begin
        sys_outputs_o[0] = tmr_voted_i;
        for (int i = 1; i < TMR_CORES; i++) begin
          sys_outputs_o[i] = '0;
        end
        // Port 3 keeps core 3, which stays independent
      end
      MODE_DMR: begin
        // Checked pairs pass their main core straight through
        for (int g = 0; g < NUM_DMR_GROUPS; g++) begin
          sys_outputs_o[2*g+1] = '0;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== hmr_vote_stage.sv ====
// Bitwise TMR majority voter and DMR pair checkers with mode-gated error flags
`timescale 1ns/10ps

module hmr_vote_stage
  import hmr_pkg::*;
(
  input  hmr_mode_e                 mode_i,
  input  core_out_t [NUM_CORES-1:0] core_outputs_i,

  // Voted triple output
  output core_out_t                 tmr_voted_o,

  // Status
  output logic [TMR_CORES-1:0]      tmr_error_o,
  output logic                      tmr_failure_o,
  output logic [NUM_DMR_GROUPS-1:0] dmr_failure_o,

  // One pulse per core towards the counters
  output logic [NUM_CORES-1:0]      incr_mismatch_o
);

  logic [OUT_W-1:0]          out_a;
  logic [OUT_W-1:0]          out_b;
  logic [OUT_W-1:0]          out_c;
  logic [OUT_W-1:0]          majority;
  logic [TMR_CORES-1:0]      tmr_flag;
  logic                      tmr_multi;
  logic [NUM_DMR_GROUPS-1:0] pair_diff;

  // Triple is cores 0 to 2
  assign out_a = core_outputs_i[0];
  assign out_b = core_outputs_i[1];
  assign out_c = core_outputs_i[2];

  // Each bit follows at least two of the three cores
  assign majority    = (out_a & out_b) | (out_a & out_c) | (out_b & out_c);
  assign tmr_voted_o = core_out_t'(majority);

  // A core is flagged if it disagrees with the vote in any bit
  for (genvar k = 0; k < TMR_CORES; k++) begin : gen_tmr_flag
    assign tmr_flag[k] = (core_outputs_i[k] != core_out_t'(majority));
  end

  // Two or more dissenting cores, the vote can no longer be trusted
  assign tmr_multi = (tmr_flag[0] & tmr_flag[1]) |
                     (tmr_flag[0] & tmr_flag[2]) |
                     (tmr_flag[1] & tmr_flag[2]);

  // Pairs are cores 0/1 and 2/3
  for (genvar g = 0; g < NUM_DMR_GROUPS; g++) begin : gen_dmr_check
    assign pair_diff[g] = (core_outputs_i[2*g] != core_outputs_i[2*g+1]);
  end

  // Only the active mode reports anything
  always_comb begin
    tmr_error_o     = '0;
    tmr_failure_o   = 1'b0;
    dmr_failure_o   = '0;
    incr_mismatch_o = '0;
    case (mode_i)
      MODE_TMR: begin
        tmr_error_o   = tmr_flag;
        tmr_failure_o = tmr_multi;
        // Core 3 runs on its own and is never counted here
        incr_mismatch_o[TMR_CORES-1:0] = tmr_flag;
      end
      MODE_DMR: begin
        dmr_failure_o = pair_diff;
        // No way to tell which core of a pair is wrong, so blame both
        for (int g = 0; g < NUM_DMR_GROUPS; g++) begin
          incr_mismatch_o[2*g]   = pair_diff[g];
          incr_mismatch_o[2*g+1] = pair_diff[g];
        end
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== hmr_config_regs.sv ====
// Configuration decode, mode register, per-core mismatch counters and read-back mux
`timescale 1ns/10ps

module hmr_config_regs
  import hmr_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,

  // Configuration port
  input  cfg_req_t              cfg_req_i,
  output logic [CFG_DATA_W-1:0] cfg_rdata_o,

  // Mismatch pulses from the vote stage
  input  logic [NUM_CORES-1:0]  incr_mismatch_i,

  // Current cluster mode
  output hmr_mode_e             mode_o
);

  hmr_mode_e                         mode_q;
  logic [NUM_CORES-1:0][CNT_W-1:0]   cnt_q;

  logic                              mode_hit;
  logic                              mode_legal;
  logic                              mode_wr;
  logic [NUM_CORES-1:0]              cnt_hit;
  logic [NUM_CORES-1:0]              cnt_clr;

  // Address decode
  assign mode_hit = (cfg_req_i.addr == ADDR_MODE);

  for (genvar i = 0; i < NUM_CORES; i++) begin : gen_cnt_decode
    assign cnt_hit[i] = (cfg_req_i.addr == (ADDR_CNT_BASE + CFG_ADDR_W'(i)));
    assign cnt_clr[i] = cfg_req_i.we & cnt_hit[i];
  end

  // Only 0 to 2 are modes, anything above is dropped
  assign mode_legal = (cfg_req_i.wdata <= CFG_DATA_W'(MODE_TMR));
  assign mode_wr    = cfg_req_i.we & mode_hit & mode_legal;

  // Mode register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mode_q <= MODE_INDEP;
    end else if (mode_wr) begin
      mode_q <= hmr_mode_e'(cfg_req_i.wdata[1:0]);
    end
  end

  // Mismatch counters
  // A software clear beats a mismatch in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < NUM_CORES; i++) begin
        if (cnt_clr[i]) begin
          cnt_q[i] <= '0;
        end else if (incr_mismatch_i[i] && (cnt_q[i] != CNT_MAX)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // Read-back, combinational on the request address
  always_comb begin
    cfg_rdata_o = '0;
    if (mode_hit) begin
      cfg_rdata_o = CFG_DATA_W'(mode_q);
    end
    for (int i = 0; i < NUM_CORES; i++) begin
      if (cnt_hit[i]) begin
        cfg_rdata_o = CFG_DATA_W'(cnt_q[i]);
      end
    end
  end

  assign mode_o = mode_q;

endmodule

// ==== hmr_pkg.sv ====
// Cluster constants, mode enum, configuration address map and core/config structs
package hmr_pkg;

  // Fixed cluster shape
  localparam int unsigned NUM_CORES      = 4;
  localparam int unsigned NUM_DMR_GROUPS = 2;
  localparam int unsigned TMR_CORES      = 3;

  // Mismatch counters
  localparam int unsigned CNT_W = 8;

  // Configuration port
  localparam int unsigned CFG_ADDR_W = 4;
  localparam int unsigned CFG_DATA_W = 8;

  // Core bus field widths
  localparam int unsigned BUS_ADDR_W = 16;
  localparam int unsigned BUS_DATA_W = 32;

  // Cluster operating mode, value 3 is not a legal mode
  typedef enum logic [1:0] {
    MODE_INDEP = 2'd0,
    MODE_DMR   = 2'd1,
    MODE_TMR   = 2'd2
  } hmr_mode_e;

  // Register map
  localparam logic [CFG_ADDR_W-1:0] ADDR_MODE     = 4'd0;
  // Counters of cores 0 to 3 sit at consecutive addresses from here
  localparam logic [CFG_ADDR_W-1:0] ADDR_CNT_BASE = 4'd4;

  // Counters stop at this value
  localparam logic [CNT_W-1:0] CNT_MAX = {CNT_W{1'b1}};

  // System side to core
  typedef struct packed {
    logic                  fetch_en;
    logic [BUS_ADDR_W-1:0] boot_addr;
    logic [BUS_DATA_W-1:0] irq_id;
  } core_in_t;

  // Core to system side
  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [BUS_ADDR_W-1:0] addr;
    logic [BUS_DATA_W-1:0] wdata;
  } core_out_t;

  // Flat width of one core output bundle, used by the bitwise voter
  localparam int unsigned OUT_W = $bits(core_out_t);

  // Configuration write or read request
  typedef struct packed {
    logic                  we;
    logic [CFG_ADDR_W-1:0] addr;
    logic [CFG_DATA_W-1:0] wdata;
  } cfg_req_t;

endpackage
